/* logic/rx_stats_consts.svh */
// ************************************************************
// widths and APB register offsets of the rx frame statistics
// block. include in any file that needs a width or an offset.
// ************************************************************
`ifndef RX_STATS_CONSTS_SVH
`define RX_STATS_CONSTS_SVH

// stream widths.
`define RX_DATA_W 64 // tdata width, bits (data itself is not kept).
`define RX_STRB_W 8 // one strobe bit per data byte.

// counter and register width.
`define RX_CNT_W 32

// APB byte offsets.
`define REG_FRAMES 8'h00 // frames received, read only.
`define REG_LAST_BYTES 8'h04 // byte count of the last frame.
`define REG_LAST_BEATS 8'h08 // beat count of the last frame.
`define REG_ERR_FRAMES 8'h0C // frames with bad strobe or tuser.
`define REG_CTRL 8'h10 // bit 0 clears both frame counters.

`endif

/* logic/rx_stats_pkg.sv */
// ************************************************************
// shared types of the rx frame statistics block. modules pull
// these in with a wildcard import in their header.
// ************************************************************
`include "rx_stats_consts.svh"

package rx_stats_pkg;

	// receive fsm states.
	typedef enum logic [1:0] {
		FRAME_IDLE = 2'd0, // one dead cycle before accepting data.
		FRAME_DATA = 2'd1, // tready high, beats are counted.
		FRAME_DONE = 2'd2 // result presented to the register block.
	} frame_state_t;

	// register picked by an APB address.
	typedef enum logic [2:0] {
		SEL_FRAMES = 3'd0,
		SEL_LAST_BYTES = 3'd1,
		SEL_LAST_BEATS = 3'd2,
		SEL_ERR_FRAMES = 3'd3,
		SEL_CTRL = 3'd4,
		REG_NONE = 3'd7 // unmapped offset.
	} reg_sel_t;

	typedef logic [`RX_CNT_W-1:0] stat_cnt_t; // counters and registers.

endpackage

/* logic/frame_result_if.sv */
// ************************************************************
// result of one finished frame, passed from the frame counter
// to the register block. done is a one-cycle pulse.
// ************************************************************
interface frame_result_if
	import rx_stats_pkg::*;
	();

	logic done; // one cycle per finished frame.
	stat_cnt_t byte_cnt; // valid with done.
	stat_cnt_t beat_cnt; // valid with done.
	logic bad; // illegal strobe or tuser seen in the frame.

	modport source (output done, output byte_cnt, output beat_cnt, output bad);

	modport sink (input done, input byte_cnt, input beat_cnt, input bad);

endinterface

/* logic/rx_frame_counter.sv */
// ************************************************************
// receive side of the MAC stream. drives tready from the fsm,
// checks each strobe and counts bytes and beats per frame.
// the finished frame goes out as a done pulse on result.
// ************************************************************
`include "rx_stats_consts.svh"

module rx_frame_counter
	import rx_stats_pkg::*;
	(
	input logic rx_mac_aclk, // rx clock.
	input logic reset_, // sync, active low.
	input logic tvalid, // beat valid from the MAC.
	input logic tlast, // last beat of the frame.
	input logic tuser, // MAC error flag.
	input logic [`RX_STRB_W-1:0] tstrb, // byte enables.
	output logic tready, // we accept beats in FRAME_DATA only.
	frame_result_if.source result // finished frame out.
	);

	frame_state_t state; // receive fsm.
	stat_cnt_t byte_cnt; // bytes so far in this frame.
	stat_cnt_t beat_cnt; // beats so far in this frame.
	logic bad; // sticky error for this frame.

	logic xfer; // a beat moves this cycle.
	logic [`RX_STRB_W-1:0] strb_inc; // tstrb + 1, for the mask check.
	logic strb_mask; // strobe is a nonzero run of low ones.
	logic strb_ok; // strobe legal for this beat.
	stat_cnt_t beat_bytes; // bytes this beat adds.

	assign tready = (state == FRAME_DATA);
	assign xfer = tvalid & tready;

	// a run of low ones turns into a single carry when one is added.
	assign strb_inc = tstrb + {{(`RX_STRB_W-1){1'b0}}, 1'b1};
	assign strb_mask = (tstrb != '0) && ((tstrb & strb_inc) == '0);

	// full strobe mid frame, any low run on the last beat.
	assign strb_ok = tlast ? strb_mask : (&tstrb);

	always_comb
	begin
		if (strb_ok)
			beat_bytes = stat_cnt_t'($countones(tstrb)); // n low bits set is n bytes.
		else
			beat_bytes = '0; // illegal strobe adds nothing.
	end

	// frame fsm and per-frame counts.
	always_ff @(posedge rx_mac_aclk)
	begin
		if (!reset_)
		begin
			state <= FRAME_IDLE;
			byte_cnt <= '0;
			beat_cnt <= '0;
			bad <= 1'b0;
		end
		else
		begin
			case (state)
				FRAME_IDLE:
				begin
					state <= FRAME_DATA; // open for the next frame.
				end
				FRAME_DATA:
				begin
					if (xfer) // stalls leave counts alone.
					begin
						byte_cnt <= byte_cnt + beat_bytes;
						beat_cnt <= beat_cnt + 1'b1;
						bad <= bad | ~strb_ok | tuser;
						if (tlast)
							state <= FRAME_DONE; // tready drops next cycle.
					end
				end
				FRAME_DONE:
				begin
					state <= FRAME_IDLE;
					byte_cnt <= '0; // result was taken this cycle.
					beat_cnt <= '0;
					bad <= 1'b0;
				end
				default:
				begin
					state <= FRAME_IDLE;
				end
			endcase
		end
	end

	// result is valid for the one FRAME_DONE cycle.
	assign result.done = (state == FRAME_DONE);
	assign result.byte_cnt = byte_cnt;
	assign result.beat_cnt = beat_cnt;
	assign result.bad = bad;

endmodule

/* logic/rx_stats_regs.sv */
// ************************************************************
// APB3 slave with the frame statistics registers. takes each
// frame result on the edge after done. no wait states.
// writes go to the control register only.
// ************************************************************
`include "rx_stats_consts.svh"

module rx_stats_regs
	import rx_stats_pkg::*;
	(
	input logic rx_mac_aclk, // rx clock, also the APB clock.
	input logic reset_, // sync, active low.
	frame_result_if.sink result, // from the frame counter.
	input logic psel, // APB select.
	input logic penable, // APB access phase.
	input logic pwrite, // 1 write, 0 read.
	input logic [7:0] paddr, // byte offset.
	input stat_cnt_t pwdata, // write data, bit 0 used.
	output stat_cnt_t prdata, // read data, access phase only.
	output logic pready, // always ready in access.
	output logic pslverr // bad offset or illegal write.
	);

	stat_cnt_t frame_cnt; // frames received.
	stat_cnt_t err_cnt; // frames marked bad.
	stat_cnt_t last_bytes; // bytes of the last frame.
	stat_cnt_t last_beats; // beats of the last frame.

	reg_sel_t sel; // decoded paddr.
	logic access; // APB access phase.
	logic clear; // clear write to the control register.
	stat_cnt_t frame_base; // frame count after a clear.
	stat_cnt_t err_base; // error count after a clear.

	// address decode.
	always_comb
	begin
		case (paddr)
			`REG_FRAMES: sel = SEL_FRAMES;
			`REG_LAST_BYTES: sel = SEL_LAST_BYTES;
			`REG_LAST_BEATS: sel = SEL_LAST_BEATS;
			`REG_ERR_FRAMES: sel = SEL_ERR_FRAMES;
			`REG_CTRL: sel = SEL_CTRL;
			default: sel = REG_NONE;
		endcase
	end

	assign access = psel & penable;
	assign pready = access;
	assign pslverr = access && ((sel == REG_NONE) || (pwrite && (sel != SEL_CTRL)));
	assign clear = access && pwrite && (sel == SEL_CTRL) && pwdata[0];

	// a clear and a done in one cycle leave the new frame counted.
	assign frame_base = clear ? '0 : frame_cnt;
	assign err_base = clear ? '0 : err_cnt;

	always_ff @(posedge rx_mac_aclk)
	begin
		if (!reset_)
		begin
			frame_cnt <= '0;
			err_cnt <= '0;
			last_bytes <= '0;
			last_beats <= '0;
		end
		else
		begin
			frame_cnt <= frame_base + stat_cnt_t'(result.done);
			err_cnt <= err_base + stat_cnt_t'(result.done & result.bad);
			if (result.done) // latch the finished frame.
			begin
				last_bytes <= result.byte_cnt;
				last_beats <= result.beat_cnt;
			end
		end
	end

	// read mux, zero outside a read access.
	always_comb
	begin
		prdata = '0;
		if (access && !pwrite)
		begin
			case (sel)
				SEL_FRAMES: prdata = frame_cnt;
				SEL_LAST_BYTES: prdata = last_bytes;
				SEL_LAST_BEATS: prdata = last_beats;
				SEL_ERR_FRAMES: prdata = err_cnt;
				default: prdata = '0; // control reads as zero.
			endcase
		end
	end

endmodule

/* logic/rx_stats_top.sv */
// ************************************************************
// rx frame statistics top level. MAC receive stream in, APB3
// slave for the host. frame results are readable two cycles
// after the tlast beat transfers.
// ************************************************************
`include "rx_stats_consts.svh"

module rx_stats_top (
	input logic rx_mac_aclk, // rx clock.
	input logic reset_, // sync, active low.

	// MAC receive stream.
	input logic rx_axis_mac_tvalid, // beat valid.
	input logic rx_axis_mac_tlast, // last beat of frame.
	input logic rx_axis_mac_tuser, // MAC error flag.
	input logic [`RX_STRB_W-1:0] rx_axis_mac_tstrb, // byte enables.
	output logic rx_axis_mac_tready, // beat accepted.

	// host APB3.
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr, // byte offset.
	input logic [`RX_CNT_W-1:0] pwdata,
	output logic [`RX_CNT_W-1:0] prdata,
	output logic pready,
	output logic pslverr
	);

	frame_result_if u_result (); // one frame result per done.

	rx_frame_counter u_frame_counter (
		.rx_mac_aclk (rx_mac_aclk),
		.reset_ (reset_),
		.tvalid (rx_axis_mac_tvalid),
		.tlast (rx_axis_mac_tlast),
		.tuser (rx_axis_mac_tuser),
		.tstrb (rx_axis_mac_tstrb),
		.tready (rx_axis_mac_tready),
		.result (u_result.source)
	);

	rx_stats_regs u_stats_regs (
		.rx_mac_aclk (rx_mac_aclk),
		.reset_ (reset_),
		.result (u_result.sink),
		.psel (psel),
		.penable (penable),
		.pwrite (pwrite),
		.paddr (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr (pslverr)
	);

endmodule

/* test/rx_stats_properties.sv */
// ************************************************************
// concurrent checks on the rx fsm and the APB slave. bound into
// the frame counter and the register block below.
// ************************************************************
module rx_stats_properties
	import rx_stats_pkg::*;
	(
	input logic rx_mac_aclk,
	input logic reset_,
	input frame_state_t state, // receive fsm.
	input logic tvalid,
	input logic tready,
	input logic tlast,
	input logic done, // frame result pulse.
	input logic psel,
	input logic penable,
	input logic pready
	);

	// closed through FRAME_DONE and FRAME_IDLE, open again after.
	a_tready_closed: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
		(state == FRAME_DONE) |-> !tready ##1 !tready ##1 tready)
		else $error("tready not closed for exactly FRAME_DONE and FRAME_IDLE");

	a_done_pulse: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
		done |=> !done)
		else $error("done held for more than one cycle");

	// access phase must follow a setup phase.
	a_pready_access: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
		pready |-> (psel && penable && $past(psel && !penable)))
		else $error("pready outside an APB access phase");

	a_gap_after_last: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
		(tvalid && tready && tlast) |=> !tready)
		else $error("tready still high after a tlast transfer");

endmodule

bind rx_frame_counter rx_stats_properties u_counter_props (
	.rx_mac_aclk (rx_mac_aclk),
	.reset_ (reset_),
	.state (state),
	.tvalid (tvalid),
	.tready (tready),
	.tlast (tlast),
	.done (result.done),
	.psel (1'b0),
	.penable (1'b0),
	.pready (1'b0)
);

bind rx_stats_regs rx_stats_properties u_regs_props (
	.rx_mac_aclk (rx_mac_aclk),
	.reset_ (reset_),
	.state (rx_stats_pkg::FRAME_DATA),
	.tvalid (1'b0),
	.tready (1'b1),
	.tlast (1'b0),
	.done (result.done),
	.psel (psel),
	.penable (penable),
	.pready (pready)
);

/* test/rx_stats_tb.sv */
// ************************************************************
// testbench for the rx frame statistics block. plays the frames
// of the stimulus file twice, first clean and then with random
// tvalid stalls, and reads the APB registers after each frame.
// ************************************************************
`include "rx_stats_consts.svh"

module rx_stats_tb
	import rx_stats_pkg::*;
	();

	localparam int WAIT_LIMIT = 100; // cycles before a wait gives up.

	logic rx_mac_aclk;
	logic reset_;
	logic tvalid;
	logic tlast;
	logic tuser;
	logic [`RX_STRB_W-1:0] tstrb;
	logic tready;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	stat_cnt_t pwdata;
	stat_cnt_t prdata;
	logic pready;
	logic pslverr;

	int errors; // wrong values seen.
	int timeouts; // waits that gave up.
	logic [31:0] rng; // xorshift state for the stalls.
	stat_cnt_t exp_frames; // frames sent since the last clear.
	stat_cnt_t exp_errs; // bad frames sent since the last clear.

	rx_stats_top u_rx_stats_top (
		.rx_mac_aclk (rx_mac_aclk),
		.reset_ (reset_),
		.rx_axis_mac_tvalid (tvalid),
		.rx_axis_mac_tlast (tlast),
		.rx_axis_mac_tuser (tuser),
		.rx_axis_mac_tstrb (tstrb),
		.rx_axis_mac_tready (tready),
		.psel (psel),
		.penable (penable),
		.pwrite (pwrite),
		.paddr (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr (pslverr)
	);

	initial
	begin
		rx_mac_aclk = 1'b0;
		forever #10 rx_mac_aclk = ~rx_mac_aclk; // period 20.
	end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic report_timeout(input string what);
		$display("timeout at %0t: %s", $time, what);
		timeouts++;
	endtask

	// present one beat, optionally after a few idle cycles, and wait for it to move.
	task automatic send_beat(input logic [7:0] strb, input logic user, input logic last,
		input bit stall);
		int gap;
		int t;
		gap = 0;
		if (stall)
		begin
			rng = next_random(rng);
			gap = int'(rng % 3);
		end
		if (gap > 0)
			tvalid <= 1'b0; // stall inside the frame.
		repeat (gap) @(posedge rx_mac_aclk);
		tvalid <= 1'b1;
		tstrb <= strb;
		tuser <= user;
		tlast <= last;
		t = 0;
		@(negedge rx_mac_aclk);
		while (!tready && t < WAIT_LIMIT)
		begin
			@(negedge rx_mac_aclk);
			t++;
		end
		if (!tready)
			report_timeout("the receiver never raised tready for a beat");
		@(posedge rx_mac_aclk); // beat transfers on this edge.
	endtask

	// tready must stay low for two cycles, then the receiver reopens.
	task automatic close_frame();
		int t;
		tvalid <= 1'b0;
		tlast <= 1'b0;
		tuser <= 1'b0;
		repeat (2)
		begin
			@(negedge rx_mac_aclk);
			if (tready)
			begin
				$display("error at %0t: tready high in the gap after tlast", $time);
				errors++;
			end
		end
		t = 0;
		while (!tready && t < WAIT_LIMIT)
		begin
			@(negedge rx_mac_aclk);
			t++;
		end
		if (!tready)
			report_timeout("the receiver did not reopen after a frame");
		@(posedge rx_mac_aclk);
	endtask

	// one APB transfer, setup then access. starts and ends on a rising edge.
	task automatic apb_access(input logic write, input logic [7:0] addr, input stat_cnt_t wdata,
		output stat_cnt_t rdata, output logic err);
		int t;
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge rx_mac_aclk);
		penable <= 1'b1; // access phase.
		t = 0;
		@(negedge rx_mac_aclk);
		while (!pready && t < WAIT_LIMIT)
		begin
			@(negedge rx_mac_aclk);
			t++;
		end
		if (!pready)
			report_timeout("the APB slave never raised pready");
		rdata = prdata;
		err = pslverr;
		@(posedge rx_mac_aclk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic check_reg(input logic [7:0] addr, input stat_cnt_t exp, input string name);
		stat_cnt_t got;
		logic err;
		apb_access(1'b0, addr, '0, got, err);
		if (got !== exp || err !== 1'b0)
		begin
			$display("error at %0t: %s read %0d, expected %0d, pslverr %b",
				$time, name, got, exp, err);
			errors++;
		end
	endtask

	task automatic check_slverr(input logic write, input logic [7:0] addr, input string name);
		stat_cnt_t got;
		logic err;
		apb_access(write, addr, 32'h1, got, err);
		if (err !== 1'b1)
		begin
			$display("error at %0t: %s gave no pslverr", $time, name);
			errors++;
		end
	endtask

	task automatic check_frame(input int bytes, input int beats, input logic bad);
		close_frame();
		exp_frames++;
		if (bad)
			exp_errs++;
		check_reg(`REG_LAST_BYTES, stat_cnt_t'(bytes), "last bytes");
		check_reg(`REG_LAST_BEATS, stat_cnt_t'(beats), "last beats");
		check_reg(`REG_FRAMES, exp_frames, "frames");
		check_reg(`REG_ERR_FRAMES, exp_errs, "error frames");
	endtask

	// kind 1 lines are beats, kind 2 lines close a frame with its expected results.
	task automatic play_file(input bit stall);
		int fd;
		int kind;
		int a;
		int b;
		int c;
		string line;
		fd = $fopen("test/rx_stats_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("the stimulus file could not be opened");
			errors++;
			return;
		end
		while (!$feof(fd) && timeouts == 0)
		begin
			kind = 0;
			if ($fgets(line, fd) != 0)
			begin
				if ($sscanf(line, "%d %h %d %d", kind, a, b, c) == 4 && kind == 1)
					send_beat(a[7:0], b[0], c[0], stall);
				else if (kind == 2 && $sscanf(line, "%d %d %d %d", kind, a, b, c) == 4)
					check_frame(a, b, c[0]);
			end
		end
		$fclose(fd);
	endtask

	initial
	begin
		stat_cnt_t rd;
		logic err;
		errors = 0;
		timeouts = 0;
		rng = 32'h2cd3_f103;
		exp_frames = '0;
		exp_errs = '0;
		reset_ = 1'b0;
		tvalid = 1'b0;
		tlast = 1'b0;
		tuser = 1'b0;
		tstrb = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (10) @(posedge rx_mac_aclk);
		reset_ <= 1'b1;
		play_file(1'b0); // back to back beats.
		play_file(1'b1); // same frames, random stalls.
		check_slverr(1'b0, 8'h14, "read of an unmapped offset");
		check_slverr(1'b1, `REG_FRAMES, "write to the frame count");
		check_reg(`REG_FRAMES, exp_frames, "frames after a refused write");
		apb_access(1'b1, `REG_CTRL, 32'h1, rd, err);
		if (err !== 1'b0)
		begin
			$display("error at %0t: clear write gave pslverr", $time);
			errors++;
		end
		check_reg(`REG_FRAMES, '0, "frames after clear");
		check_reg(`REG_ERR_FRAMES, '0, "error frames after clear");
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* test/rx_stats_stimulus.txt */
# beat: 1 <tstrb hex> <tuser> <tlast>
# frame end: 2 <expected bytes> <expected beats> <expected bad flag>
1 ff 0 0
1 ff 0 0
1 ff 0 1
2 24 3 0
1 ff 0 0
1 07 0 1
2 11 2 0
1 01 0 1
2 1 1 0
1 ff 0 0
1 ff 0 0
1 7f 0 1
2 23 3 0
1 0f 0 0
1 ff 0 1
2 8 2 1
1 ff 0 0
1 05 0 1
2 8 2 1
1 ff 1 0
1 03 0 1
2 10 2 1
1 ff 0 1
2 8 1 0

/* sources.f */
+incdir+logic
logic/rx_stats_pkg.sv
logic/frame_result_if.sv
logic/rx_frame_counter.sv
logic/rx_stats_regs.sv
logic/rx_stats_top.sv
test/rx_stats_properties.sv
test/rx_stats_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rx frame statistics testbench with verilator.
set -u
cd "$(dirname "$0")" || { echo "cannot enter the project root"; exit 1; }

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module rx_stats_tb -Mdir obj_dir -o rx_stats_sim; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/rx_stats_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" <<< "$output"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1
